// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module emu_ctrl_tb -f tb.f -o emu_ctrl_sim
	./obj_dir/emu_ctrl_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		--top-module emu_ctrl_tb -f tb.f

clean:
	rm -rf obj_dir

// ==== logic/csr_read_slave.sv ====
`default_nettype none

module csr_read_slave (
    input  wire                          clk,
    input  wire                          rst,
    input  wire emu_bus_pkg::axil_ar_t   ar,
    input  wire                          rready,
    output logic                         arready,
    output emu_bus_pkg::axil_r_t         r,
    input  wire emu_csr_pkg::run_state_t run_state,
    input  wire                          putchar_valid,
    input  wire [7:0]                    putchar_data,
    output logic                         putchar_ready
);

    emu_bus_pkg::csr_addr_t rd_addr;
    emu_bus_pkg::csr_data_t rd_word;
    emu_bus_pkg::csr_data_t rd_data;
    logic                   addr_held;
    logic                   rd_valid;
    logic                   rd_fire;

    assign arready = !addr_held;

    // Capture happens once, in the cycle after AR is taken
    assign rd_fire = addr_held && !rd_valid;

    always_comb begin
        case (rd_addr)
            emu_csr_pkg::ADDR_STAT:      rd_word = run_state.stat;
            emu_csr_pkg::ADDR_TRIG_STAT: rd_word = run_state.trig_stat;
            emu_csr_pkg::ADDR_CYCLE_LO:  rd_word = run_state.cycle[31:0];
            emu_csr_pkg::ADDR_CYCLE_HI:  rd_word = run_state.cycle[63:32];
            emu_csr_pkg::ADDR_STEP:      rd_word = run_state.step;
            emu_csr_pkg::ADDR_TRIG_EN:   rd_word = run_state.trig_en;
            // Valid flag on top, character in the low byte
            emu_csr_pkg::ADDR_PUTCHAR:   rd_word = {putchar_valid, 23'd0, putchar_data};
            default:                     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar.valid && arready) begin
            rd_addr <= ar.addr;
        end
        if (rd_fire) begin
            rd_data <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_held <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            if (ar.valid && arready) begin
                addr_held <= 1'b1;
            end
            if (rd_fire) begin
                rd_valid <= 1'b1;
            end
            if (rd_valid && rready) begin
                addr_held <= 1'b0;
                rd_valid  <= 1'b0;
            end
        end
    end

    always_comb begin
        r.valid = rd_valid;
        r.resp  = emu_bus_pkg::RESP_OKAY;
        r.data  = rd_data;
    end

    // Console character is consumed when its word is captured
    assign putchar_ready = rd_fire && (rd_addr == emu_csr_pkg::ADDR_PUTCHAR);

endmodule

`default_nettype wire

// ==== logic/csr_write_slave.sv ====
`default_nettype none

module csr_write_slave (
    input  wire                          clk,
    input  wire                          rst,
    input  wire emu_bus_pkg::axil_aw_t   aw,
    input  wire emu_bus_pkg::axil_w_t    w,
    input  wire                          bready,
    output logic                         awready,
    output logic                         wready,
    output emu_bus_pkg::axil_b_t         b,
    output emu_bus_pkg::csr_wr_t         csr_wr
);

    emu_bus_pkg::csr_addr_t wr_addr;
    emu_bus_pkg::csr_data_t wr_data;
    logic                   addr_held;
    logic                   data_held;
    logic                   strb_err;
    logic                   wr_done;

    assign wr_done = addr_held && data_held;

    // No new address while a response is still waiting
    assign awready = !addr_held && !b.valid;
    assign wready  = !data_held;

    always_ff @(posedge clk) begin
        if (aw.valid && awready) begin
            wr_addr <= aw.addr;
        end
        if (w.valid && wready) begin
            wr_data <= w.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_held <= 1'b0;
            data_held <= 1'b0;
            strb_err  <= 1'b0;
            b.valid   <= 1'b0;
            b.resp    <= emu_bus_pkg::RESP_OKAY;
        end else begin
            if (aw.valid && awready) begin
                addr_held <= 1'b1;
            end
            if (w.valid && wready) begin
                data_held <= 1'b1;
                strb_err  <= w.strb != 4'b1111;
            end
            // Both halves present, retire the write and answer
            if (wr_done) begin
                addr_held <= 1'b0;
                data_held <= 1'b0;
                b.valid   <= 1'b1;
                b.resp    <= strb_err ? emu_bus_pkg::RESP_SLVERR : emu_bus_pkg::RESP_OKAY;
            end
            if (b.valid && bready) begin
                b.valid <= 1'b0;
            end
        end
    end

    // Partial writes are answered but never reach a register
    always_comb begin
        csr_wr.strobe = wr_done && !strb_err;
        csr_wr.addr   = wr_addr;
        csr_wr.data   = wr_data;
    end

endmodule

`default_nettype wire

// ==== logic/emu_bus_pkg.sv ====
`default_nettype none

package emu_bus_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // AXI-lite channels
    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        logic [2:0] prot;
    } axil_aw_t;

    typedef struct packed {
        logic      valid;
        csr_data_t data;
        logic [3:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axil_b_t;

    typedef axil_aw_t axil_ar_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
        csr_data_t  data;
    } axil_r_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One accepted register write
    typedef struct packed {
        logic      strobe;
        csr_addr_t addr;
        csr_data_t data;
    } csr_wr_t;

endpackage

`default_nettype wire

// ==== logic/emu_csr_pkg.sv ====
`default_nettype none

package emu_csr_pkg;

    // Register map
    localparam emu_bus_pkg::csr_addr_t ADDR_STAT      = 12'h000;
    localparam emu_bus_pkg::csr_addr_t ADDR_TRIG_STAT = 12'h004;
    localparam emu_bus_pkg::csr_addr_t ADDR_CYCLE_LO  = 12'h008;
    localparam emu_bus_pkg::csr_addr_t ADDR_CYCLE_HI  = 12'h00C;
    localparam emu_bus_pkg::csr_addr_t ADDR_STEP      = 12'h010;
    localparam emu_bus_pkg::csr_addr_t ADDR_TRIG_EN   = 12'h014;
    localparam emu_bus_pkg::csr_addr_t ADDR_PUTCHAR   = 12'h018;

    // STAT register, bit 31 down to bit 0
    typedef struct packed {
        logic        step_trig;
        logic [24:0] reserved;
        logic        down_stat;
        logic        up_stat;
        logic        down_req;
        logic        up_req;
        logic        dut_rst;
        logic        pause;
    } emu_stat_t;

    typedef logic [63:0] cycle_t;

    // Everything the read mux can show
    typedef struct packed {
        emu_stat_t              stat;
        emu_bus_pkg::csr_data_t trig_stat;
        emu_bus_pkg::csr_data_t trig_en;
        cycle_t                 cycle;
        emu_bus_pkg::csr_data_t step;
    } run_state_t;

endpackage

`default_nettype wire

// ==== logic/emu_ctrl_top.sv ====
`default_nettype none

module emu_ctrl_top #(
    parameter int NUM_TRIG = 32
) (
    input  wire                          clk,
    input  wire                          rst,
    // AXI-lite slave
    input  wire emu_bus_pkg::axil_aw_t   aw,
    output logic                         awready,
    input  wire emu_bus_pkg::axil_w_t    w,
    output logic                         wready,
    output emu_bus_pkg::axil_b_t         b,
    input  wire                          bready,
    input  wire emu_bus_pkg::axil_ar_t   ar,
    output logic                         arready,
    output emu_bus_pkg::axil_r_t         r,
    input  wire                          rready,
    // Emulated design
    input  wire                          stall_gen,
    input  wire [NUM_TRIG-1:0]           dut_trig,
    input  wire                          up_stat,
    input  wire                          down_stat,
    output logic                         up_req,
    output logic                         down_req,
    output logic                         dut_rst,
    output logic                         stall,
    output logic                         dut_run,
    // Console
    input  wire                          putchar_valid,
    input  wire [7:0]                    putchar_data,
    output logic                         putchar_ready
);

    emu_bus_pkg::csr_wr_t    csr_wr;
    emu_csr_pkg::run_state_t run_state;

    csr_write_slave u_csr_write (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .w       (w),
        .bready  (bready),
        .awready (awready),
        .wready  (wready),
        .b       (b),
        .csr_wr  (csr_wr)
    );

    csr_read_slave u_csr_read (
        .clk           (clk),
        .rst           (rst),
        .ar            (ar),
        .rready        (rready),
        .arready       (arready),
        .r             (r),
        .run_state     (run_state),
        .putchar_valid (putchar_valid),
        .putchar_data  (putchar_data),
        .putchar_ready (putchar_ready)
    );

    run_control #(
        .NUM_TRIG (NUM_TRIG)
    ) u_run_control (
        .clk       (clk),
        .rst       (rst),
        .csr_wr    (csr_wr),
        .stall_gen (stall_gen),
        .dut_trig  (dut_trig),
        .up_stat   (up_stat),
        .down_stat (down_stat),
        .up_req    (up_req),
        .down_req  (down_req),
        .dut_rst   (dut_rst),
        .stall     (stall),
        .dut_run   (dut_run),
        .run_state (run_state)
    );

endmodule

`default_nettype wire

// ==== logic/run_control.sv ====
`default_nettype none

module run_control #(
    parameter int NUM_TRIG = 32
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire emu_bus_pkg::csr_wr_t    csr_wr,
    input  wire                          stall_gen,
    input  wire [NUM_TRIG-1:0]           dut_trig,
    input  wire                          up_stat,
    input  wire                          down_stat,
    output logic                         up_req,
    output logic                         down_req,
    output logic                         dut_rst,
    output logic                         stall,
    output logic                         dut_run,
    output emu_csr_pkg::run_state_t      run_state
);

    emu_csr_pkg::emu_stat_t wr_stat;
    emu_csr_pkg::cycle_t    cycle;
    emu_bus_pkg::csr_data_t step;
    emu_bus_pkg::csr_data_t step_next;
    logic [NUM_TRIG-1:0]    trig_stat;
    logic [NUM_TRIG-1:0]    trig_en;
    logic                   pause;
    logic                   step_trig;
    logic                   step_trig_q;
    logic                   trigger;
    logic                   wr_stat_en;
    logic                   wr_step_en;
    logic                   wr_trig_en_en;
    logic                   wr_cycle_lo;
    logic                   wr_cycle_hi;

    // Register write decode
    assign wr_stat       = emu_csr_pkg::emu_stat_t'(csr_wr.data);
    assign wr_stat_en    = csr_wr.strobe && csr_wr.addr == emu_csr_pkg::ADDR_STAT;
    assign wr_step_en    = csr_wr.strobe && csr_wr.addr == emu_csr_pkg::ADDR_STEP;
    assign wr_trig_en_en = csr_wr.strobe && csr_wr.addr == emu_csr_pkg::ADDR_TRIG_EN;
    assign wr_cycle_lo   = csr_wr.strobe && csr_wr.addr == emu_csr_pkg::ADDR_CYCLE_LO;
    assign wr_cycle_hi   = csr_wr.strobe && csr_wr.addr == emu_csr_pkg::ADDR_CYCLE_HI;

    assign stall   = pause || stall_gen;
    assign dut_run = !stall;

    // Budget counts only cycles the design actually ran
    assign step_next = (dut_run && step != '0) ? step - 32'd1 : step;
    assign step_trig = step != '0 && step_next == '0;
    assign trigger   = step_trig || |(dut_trig & trig_en);

    always_ff @(posedge clk) begin
        if (rst) begin
            pause       <= 1'b1;
            dut_rst     <= 1'b1;
            up_req      <= 1'b0;
            down_req    <= 1'b0;
            step_trig_q <= 1'b0;
        end else begin
            if (wr_stat_en) begin
                pause    <= wr_stat.pause;
                dut_rst  <= wr_stat.dut_rst;
                up_req   <= wr_stat.up_req;
                down_req <= wr_stat.down_req;
            end
            // Trigger overrides a host write to pause
            if (trigger) begin
                pause       <= 1'b1;
                step_trig_q <= step_trig;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (dut_run) begin
            cycle <= cycle + 64'd1;
        end else begin
            if (wr_cycle_lo) begin
                cycle[31:0] <= csr_wr.data;
            end
            if (wr_cycle_hi) begin
                cycle[63:32] <= csr_wr.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step      <= '0;
            trig_en   <= '0;
            trig_stat <= '0;
        end else begin
            step      <= wr_step_en ? csr_wr.data : step_next;
            trig_stat <= dut_trig;
            if (wr_trig_en_en) begin
                trig_en <= csr_wr.data[NUM_TRIG-1:0];
            end
        end
    end

    always_comb begin
        run_state                = '0;
        run_state.stat.step_trig = step_trig_q;
        run_state.stat.down_stat = down_stat;
        run_state.stat.up_stat   = up_stat;
        run_state.stat.down_req  = down_req;
        run_state.stat.up_req    = up_req;
        run_state.stat.dut_rst   = dut_rst;
        run_state.stat.pause     = pause;
        run_state.trig_stat      = emu_bus_pkg::csr_data_t'(trig_stat);
        run_state.trig_en        = emu_bus_pkg::csr_data_t'(trig_en);
        run_state.cycle          = cycle;
        run_state.step           = step;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/emu_bus_pkg.sv
logic/emu_csr_pkg.sv
logic/csr_write_slave.sv
logic/csr_read_slave.sv
logic/run_control.sv
logic/emu_ctrl_top.sv
testbench/tb_clock.sv
testbench/emu_ctrl_props.sv
testbench/emu_ctrl_tb.sv

// ==== testbench/emu_ctrl_props.sv ====
`default_nettype none

module emu_ctrl_props (
    input wire        clk,
    input wire        rst,
    input wire        rsp_valid,
    input wire        rsp_ready,
    input wire [31:0] rsp_data,
    input wire        req_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // Response stays up until the master takes it
    valid_held: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid)
        else $error("response valid dropped before ready");

    data_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> $stable(rsp_data))
        else $error("response payload changed while waiting");

    // No new request accepted while one is answered
    req_blocked: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> !req_ready)
        else $error("request ready high while a response is pending");

endmodule

bind csr_write_slave emu_ctrl_props u_write_props (
    .clk       (clk),
    .rst       (rst),
    .rsp_valid (b.valid),
    .rsp_ready (bready),
    .rsp_data  ({30'd0, b.resp}),
    .req_ready (awready)
);

bind csr_read_slave emu_ctrl_props u_read_props (
    .clk       (clk),
    .rst       (rst),
    .rsp_valid (r.valid),
    .rsp_ready (rready),
    .rsp_data  (r.data),
    .req_ready (arready)
);

`default_nettype wire

// ==== testbench/emu_ctrl_tb.sv ====
`default_nettype none

module emu_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TRIG       = 32;
    // About 30 bus transfers of under 10 cycles each plus the run windows
    localparam int TIMEOUT_CYCLES = 2000;

    logic                   clk;
    logic                   rst;
    emu_bus_pkg::axil_aw_t  aw;
    emu_bus_pkg::axil_w_t   w;
    emu_bus_pkg::axil_b_t   b;
    emu_bus_pkg::axil_ar_t  ar;
    emu_bus_pkg::axil_r_t   r;
    logic                   awready;
    logic                   wready;
    logic                   arready;
    logic                   bready;
    logic                   rready;
    logic                   stall_gen;
    logic [NUM_TRIG-1:0]    dut_trig;
    logic                   up_stat;
    logic                   down_stat;
    logic                   up_req;
    logic                   down_req;
    logic                   dut_rst;
    logic                   stall;
    logic                   dut_run;
    logic                   putchar_valid;
    logic [7:0]             putchar_data;
    logic                   putchar_ready;

    int          error_count  = 0;
    int          check_count  = 0;
    int          cycle_count  = 0;
    int          run_cycles   = 0;
    int          ready_pulses = 0;
    logic        verdict_done = 1'b0;
    logic [31:0] lcg_state    = 32'h5468;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    emu_ctrl_top #(
        .NUM_TRIG (NUM_TRIG)
    ) u_emu_ctrl_top (
        .clk           (clk),
        .rst           (rst),
        .aw            (aw),
        .awready       (awready),
        .w             (w),
        .wready        (wready),
        .b             (b),
        .bready        (bready),
        .ar            (ar),
        .arready       (arready),
        .r             (r),
        .rready        (rready),
        .stall_gen     (stall_gen),
        .dut_trig      (dut_trig),
        .up_stat       (up_stat),
        .down_stat     (down_stat),
        .up_req        (up_req),
        .down_req      (down_req),
        .dut_rst       (dut_rst),
        .stall         (stall),
        .dut_run       (dut_run),
        .putchar_valid (putchar_valid),
        .putchar_data  (putchar_data),
        .putchar_ready (putchar_ready)
    );

    // Mid-cycle counts of run cycles and console pulses
    always @(negedge clk) begin
        if (dut_run) begin
            run_cycles++;
        end
        if (putchar_ready) begin
            ready_pulses++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            verdict_done = 1'b1;
            $finish;
        end
    end

    // Catches a run stopped early by a failed bus assertion
    final begin
        if (!verdict_done) begin
            $display("*** TEST FAILED ***");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_data(input string name, input emu_bus_pkg::csr_data_t actual,
                              input emu_bus_pkg::csr_data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] actual,
                              input logic [1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_cycle(input string name, input emu_csr_pkg::cycle_t actual,
                               input emu_csr_pkg::cycle_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic write_reg(input emu_bus_pkg::csr_addr_t addr,
                             input emu_bus_pkg::csr_data_t data,
                             input logic [3:0] strb, output logic [1:0] resp);
        logic aw_take;
        logic w_take;
        aw.valid = 1'b1;
        aw.addr  = addr;
        aw.prot  = 3'b000;
        w.valid  = 1'b1;
        w.data   = data;
        w.strb   = strb;
        while (aw.valid || w.valid) begin
            @(negedge clk);
            aw_take = aw.valid && awready;
            w_take  = w.valid && wready;
            @(posedge clk);
            #1;
            if (aw_take) begin
                aw.valid = 1'b0;
            end
            if (w_take) begin
                w.valid = 1'b0;
            end
        end
        bready = 1'b1;
        @(negedge clk);
        while (!b.valid) begin
            @(negedge clk);
        end
        resp = b.resp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input emu_bus_pkg::csr_addr_t addr,
                            output emu_bus_pkg::csr_data_t data, output logic [1:0] resp);
        logic ar_take;
        ar.valid = 1'b1;
        ar.addr  = addr;
        ar.prot  = 3'b000;
        while (ar.valid) begin
            @(negedge clk);
            ar_take = arready;
            @(posedge clk);
            #1;
            if (ar_take) begin
                ar.valid = 1'b0;
            end
        end
        rready = 1'b1;
        @(negedge clk);
        while (!r.valid) begin
            @(negedge clk);
        end
        data = r.data;
        resp = r.resp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic read_cycle(output emu_csr_pkg::cycle_t count);
        emu_bus_pkg::csr_data_t lo;
        emu_bus_pkg::csr_data_t hi;
        logic [1:0]             resp;
        read_reg(emu_csr_pkg::ADDR_CYCLE_LO, lo, resp);
        read_reg(emu_csr_pkg::ADDR_CYCLE_HI, hi, resp);
        count = {hi, lo};
    endtask

    task automatic reset_values();
        emu_csr_pkg::emu_stat_t stat;
        emu_bus_pkg::csr_data_t rd;
        logic [1:0]             resp;
        check_bit("dut_rst", dut_rst, 1'b1);
        check_bit("dut_run", dut_run, 1'b0);
        check_bit("bvalid", b.valid, 1'b0);
        check_bit("rvalid", r.valid, 1'b0);
        check_bit("putchar_ready", putchar_ready, 1'b0);
        stat         = '0;
        stat.pause   = 1'b1;
        stat.dut_rst = 1'b1;
        read_reg(emu_csr_pkg::ADDR_STAT, rd, resp);
        check_data("STAT", rd, stat);
        // Unmapped word
        read_reg(12'h0FC, rd, resp);
        check_data("unmapped", rd, 32'h0);
        check_resp("rresp unmapped", resp, emu_bus_pkg::RESP_OKAY);
    endtask

    task automatic write_rules();
        emu_csr_pkg::emu_stat_t stat;
        emu_bus_pkg::csr_data_t rd;
        logic [1:0]             resp;
        write_reg(emu_csr_pkg::ADDR_TRIG_EN, 32'hA5A5_A5A5, 4'b0111, resp);
        check_resp("bresp partial", resp, emu_bus_pkg::RESP_SLVERR);
        read_reg(emu_csr_pkg::ADDR_TRIG_EN, rd, resp);
        check_data("TRIG_EN after partial", rd, 32'h0);
        write_reg(emu_csr_pkg::ADDR_TRIG_EN, 32'hA5A5_A5A5, 4'b1111, resp);
        check_resp("bresp full", resp, emu_bus_pkg::RESP_OKAY);
        read_reg(emu_csr_pkg::ADDR_TRIG_EN, rd, resp);
        check_data("TRIG_EN", rd, 32'hA5A5_A5A5);
        write_reg(emu_csr_pkg::ADDR_TRIG_EN, 32'h0, 4'b1111, resp);
        // Up and down bits set one side at a time
        stat         = '0;
        stat.pause   = 1'b1;
        stat.dut_rst = 1'b1;
        stat.up_req  = 1'b1;
        write_reg(emu_csr_pkg::ADDR_STAT, stat, 4'b1111, resp);
        check_bit("up_req", up_req, 1'b1);
        check_bit("down_req", down_req, 1'b0);
        up_stat      = 1'b1;
        stat.up_stat = 1'b1;
        read_reg(emu_csr_pkg::ADDR_STAT, rd, resp);
        check_data("STAT with up bits", rd, stat);
        up_stat       = 1'b0;
        down_stat     = 1'b1;
        stat          = '0;
        stat.pause    = 1'b1;
        stat.dut_rst  = 1'b1;
        stat.down_req = 1'b1;
        write_reg(emu_csr_pkg::ADDR_STAT, stat, 4'b1111, resp);
        check_bit("up_req cleared", up_req, 1'b0);
        check_bit("down_req set", down_req, 1'b1);
        stat.down_stat = 1'b1;
        read_reg(emu_csr_pkg::ADDR_STAT, rd, resp);
        check_data("STAT with down bits", rd, stat);
        down_stat = 1'b0;
    endtask

    task automatic step_budget();
        emu_csr_pkg::emu_stat_t stat;
        emu_csr_pkg::cycle_t    count;
        emu_bus_pkg::csr_data_t rd;
        logic [1:0]             resp;
        write_reg(emu_csr_pkg::ADDR_CYCLE_LO, 32'd100, 4'b1111, resp);
        write_reg(emu_csr_pkg::ADDR_CYCLE_HI, 32'd0, 4'b1111, resp);
        write_reg(emu_csr_pkg::ADDR_STEP, 32'd7, 4'b1111, resp);
        run_cycles = 0;
        stat       = '0;
        write_reg(emu_csr_pkg::ADDR_STAT, stat, 4'b1111, resp);
        @(negedge clk);
        while (dut_run) begin
            @(negedge clk);
        end
        check_data("dut_run cycles", run_cycles, 32'd7);
        @(posedge clk);
        #1;
        stat.pause     = 1'b1;
        stat.step_trig = 1'b1;
        read_reg(emu_csr_pkg::ADDR_STAT, rd, resp);
        check_data("STAT after step", rd, stat);
        read_cycle(count);
        check_cycle("cycle after step", count, 64'd107);
    endtask

    task automatic external_stall();
        emu_csr_pkg::emu_stat_t stat;
        emu_csr_pkg::cycle_t    count;
        logic [1:0]             resp;
        stall_gen = 1'b1;
        stat      = '0;
        write_reg(emu_csr_pkg::ADDR_STAT, stat, 4'b1111, resp);
        run_cycles = 0;
        repeat (20) @(posedge clk);
        #1;
        check_bit("stall", stall, 1'b1);
        check_data("dut_run cycles under stall", run_cycles, 32'd0);
        read_cycle(count);
        check_cycle("cycle under stall", count, 64'd107);
        // Pause is already clear, so the design runs from here
        stall_gen = 1'b0;
    endtask

    task automatic trigger_pause();
        emu_csr_pkg::emu_stat_t stat;
        emu_bus_pkg::csr_data_t rd;
        logic [1:0]             resp;
        write_reg(emu_csr_pkg::ADDR_TRIG_EN, 32'h0000_0008, 4'b1111, resp);
        dut_trig = 32'h0000_0020;
        repeat (5) @(posedge clk);
        #1;
        check_bit("dut_run with masked trigger", dut_run, 1'b1);
        dut_trig = 32'h0000_0028;
        @(posedge clk);
        #1;
        check_bit("dut_run after trigger", dut_run, 1'b0);
        read_reg(emu_csr_pkg::ADDR_TRIG_STAT, rd, resp);
        check_data("TRIG_STAT", rd, 32'h0000_0028);
        stat       = '0;
        stat.pause = 1'b1;
        read_reg(emu_csr_pkg::ADDR_STAT, rd, resp);
        check_data("STAT after trigger", rd, stat);
        dut_trig = '0;
    endtask

    task automatic console_read();
        emu_bus_pkg::csr_data_t rd;
        logic [31:0]            rnd;
        logic [7:0]             ch;
        logic [1:0]             resp;
        rnd           = lcg_next();
        ch            = rnd[23:16];
        putchar_valid = 1'b1;
        putchar_data  = ch;
        ready_pulses  = 0;
        read_reg(emu_csr_pkg::ADDR_PUTCHAR, rd, resp);
        check_data("PUTCHAR", rd, {1'b1, 23'd0, ch});
        check_data("putchar_ready cycles", ready_pulses, 32'd1);
        putchar_valid = 1'b0;
    endtask

    initial begin
        rst           = 1'b1;
        aw            = '0;
        w             = '0;
        ar            = '0;
        bready        = 1'b0;
        rready        = 1'b0;
        stall_gen     = 1'b0;
        dut_trig      = '0;
        up_stat       = 1'b0;
        down_stat     = 1'b0;
        putchar_valid = 1'b0;
        putchar_data  = 8'h00;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_values();
        write_rules();
        step_budget();
        external_stall();
        trigger_pause();
        console_read();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        verdict_done = 1'b1;
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // 4 ns period
    always begin
        #2;
        clk = ~clk;
    end

endmodule

`default_nettype wire
